// File: common/icb_pkg.sv
// Bus widths for the internal RAM port
// Command and response payload structs
package icb_pkg;

  localparam int AW = 16;
  localparam int DW = 64;
  localparam int MW = 8;

  typedef logic [AW-1:0] addr_t;
  typedef logic [DW-1:0] data_t;
  typedef logic [MW-1:0] mask_t;

  // 89 bits
  typedef struct packed {
    logic  read;
    addr_t addr;
    data_t wdata;
    mask_t wmask;
  } cmd_t;

  // 65 bits
  typedef struct packed {
    logic  err;
    data_t rdata;
  } rsp_t;

endpackage

// File: common/arbt_pkg.sv
// Arbitration constants, master id type
// Response tagged with the issuing master
package arbt_pkg;

  localparam int NUM_MASTERS = 2;
  localparam int OUTS_NUM    = 4;

  typedef logic [0:0] mid_t;

  typedef struct packed {
    mid_t          mid;
    icb_pkg::rsp_t rsp;
  } routed_rsp_t;

endpackage

// File: verilog/icb_buffer.sv
// Two-entry valid/ready FIFO, generic payload
// Output taken straight from the storage flops
`timescale 1ns/1ps

module icb_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready,
  output logic     o_busy
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // Ready depends on the count only
  assign o_ready = (count != 2'd2);
  assign o_valid = (count != 2'd0);
  assign o_busy  = o_valid;
  assign o_data  = mem[rd_ptr];

  assign push = i_valid & o_ready;
  assign pop  = o_valid & i_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      wr_ptr <= wr_ptr ^ push;
      rd_ptr <= rd_ptr ^ pop;
      count  <= count + {1'b0, push} - {1'b0, pop};
    end
  end

endmodule

// File: arbt/icb_arbiter.sv
// Round-robin arbiter for two command masters
// Forwards the granted command and pushes its master id
`timescale 1ns/1ps

module icb_arbiter (
  input  logic                             clk,
  input  logic                             i_rst,
  input  logic [arbt_pkg::NUM_MASTERS-1:0] i_cmd_valid,
  input  icb_pkg::cmd_t                    i0_cmd,
  input  icb_pkg::cmd_t                    i1_cmd,
  output logic [arbt_pkg::NUM_MASTERS-1:0] o_cmd_ready,
  output logic                             o_cmd_valid,
  output icb_pkg::cmd_t                    o_cmd,
  input  logic                             i_cmd_ready,
  output logic                             o_push_valid,
  output arbt_pkg::mid_t                   o_push_mid,
  input  logic                             i_push_ready
);

  arbt_pkg::mid_t rr_ptr;
  arbt_pkg::mid_t gnt_mid;
  logic           any_req;
  logic           xfer;

  assign any_req = |i_cmd_valid;

  // Favoured master wins, else the other one
  always_comb begin
    if (i_cmd_valid[rr_ptr]) begin
      gnt_mid = rr_ptr;
    end else begin
      gnt_mid = ~rr_ptr;
    end
  end

  // Command leaves only with room in both the buffer and the id FIFO
  assign o_cmd_valid  = any_req & i_push_ready;
  assign o_push_valid = any_req & i_cmd_ready;
  assign o_push_mid   = gnt_mid;
  assign xfer         = any_req & i_cmd_ready & i_push_ready;

  assign o_cmd = (gnt_mid == 1'b1) ? i1_cmd : i0_cmd;

  always_comb begin
    o_cmd_ready          = '0;
    o_cmd_ready[gnt_mid] = xfer;
  end

  // Pointer hands priority to the loser after each transfer
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rr_ptr <= '0;
    end else if (xfer) begin
      rr_ptr <= ~gnt_mid;
    end
  end

endmodule

// File: arbt/icb_rsp_route.sv
// Outstanding master id FIFO
// Response buffer and per-master response steering
`timescale 1ns/1ps

module icb_rsp_route (
  input  logic                             clk,
  input  logic                             i_rst,
  input  logic                             i_push_valid,
  input  arbt_pkg::mid_t                   i_push_mid,
  output logic                             o_push_ready,
  input  logic                             i_rsp_valid,
  input  icb_pkg::rsp_t                    i_rsp,
  output logic                             o_rsp_ready,
  output logic [arbt_pkg::NUM_MASTERS-1:0] o_rsp_valid,
  output icb_pkg::rsp_t                    o_rsp,
  input  logic [arbt_pkg::NUM_MASTERS-1:0] i_rsp_ready,
  output logic                             o_busy
);

  arbt_pkg::mid_t                          mid_q [arbt_pkg::OUTS_NUM];
  logic [$clog2(arbt_pkg::OUTS_NUM)-1:0]   wr_ptr;
  logic [$clog2(arbt_pkg::OUTS_NUM)-1:0]   rd_ptr;
  logic [$clog2(arbt_pkg::OUTS_NUM):0]     outs_cnt;
  logic                                    push;
  logic                                    pop;
  arbt_pkg::routed_rsp_t                   tagged_rsp;
  logic                                    buf_valid;
  arbt_pkg::routed_rsp_t                   buf_data;
  logic                                    buf_busy;

  assign o_push_ready = (outs_cnt < arbt_pkg::OUTS_NUM);
  assign push         = i_push_valid & o_push_ready;
  assign pop          = i_rsp_valid & o_rsp_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mid_q[wr_ptr] <= i_push_mid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      outs_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      outs_cnt <= outs_cnt + push - pop;
    end
  end

  // Responses return in order, so the oldest id owns this one
  assign tagged_rsp.mid = mid_q[rd_ptr];
  assign tagged_rsp.rsp = i_rsp;

  icb_buffer #(
    .payload_t (arbt_pkg::routed_rsp_t)
  ) u_rsp_buf (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_rsp_valid),
    .i_data  (tagged_rsp),
    .o_ready (o_rsp_ready),
    .o_valid (buf_valid),
    .o_data  (buf_data),
    .i_ready (i_rsp_ready[buf_data.mid]),
    .o_busy  (buf_busy)
  );

  always_comb begin
    for (int k = 0; k < arbt_pkg::NUM_MASTERS; k++) begin
      o_rsp_valid[k] = buf_valid & (buf_data.mid == arbt_pkg::mid_t'(k));
    end
  end

  assign o_rsp  = buf_data.rsp;
  assign o_busy = (outs_cnt != '0) | buf_busy;

endmodule

// File: verilog/icb_nto1_bus.sv
// Two-master to one-slave bus for the internal RAM port
// Arbiter, command buffer and response router
`timescale 1ns/1ps

module icb_nto1_bus (
  input  logic           clk,
  input  logic           i_rst,
  input  logic           i0_cmd_valid,
  input  logic           i1_cmd_valid,
  input  icb_pkg::cmd_t  i0_cmd,
  input  icb_pkg::cmd_t  i1_cmd,
  output logic           o0_cmd_ready,
  output logic           o1_cmd_ready,
  output logic           o0_rsp_valid,
  output logic           o1_rsp_valid,
  output icb_pkg::rsp_t  o_rsp,
  input  logic           i0_rsp_ready,
  input  logic           i1_rsp_ready,
  output logic           o_icb_cmd_valid,
  output icb_pkg::cmd_t  o_icb_cmd,
  input  logic           i_icb_cmd_ready,
  input  logic           i_icb_rsp_valid,
  input  icb_pkg::rsp_t  i_icb_rsp,
  output logic           o_icb_rsp_ready,
  output logic           o_active
);

  logic [arbt_pkg::NUM_MASTERS-1:0] mst_cmd_valid;
  logic [arbt_pkg::NUM_MASTERS-1:0] mst_cmd_ready;
  logic [arbt_pkg::NUM_MASTERS-1:0] mst_rsp_valid;
  logic [arbt_pkg::NUM_MASTERS-1:0] mst_rsp_ready;
  logic                             arbt_cmd_valid;
  icb_pkg::cmd_t                    arbt_cmd;
  logic                             arbt_cmd_ready;
  logic                             push_valid;
  arbt_pkg::mid_t                   push_mid;
  logic                             push_ready;
  logic                             cmd_busy;
  logic                             rsp_busy;

  assign mst_cmd_valid = {i1_cmd_valid, i0_cmd_valid};
  assign mst_rsp_ready = {i1_rsp_ready, i0_rsp_ready};
  assign {o1_cmd_ready, o0_cmd_ready} = mst_cmd_ready;
  assign {o1_rsp_valid, o0_rsp_valid} = mst_rsp_valid;

  icb_arbiter u_arbiter (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_cmd_valid  (mst_cmd_valid),
    .i0_cmd       (i0_cmd),
    .i1_cmd       (i1_cmd),
    .o_cmd_ready  (mst_cmd_ready),
    .o_cmd_valid  (arbt_cmd_valid),
    .o_cmd        (arbt_cmd),
    .i_cmd_ready  (arbt_cmd_ready),
    .o_push_valid (push_valid),
    .o_push_mid   (push_mid),
    .i_push_ready (push_ready)
  );

  icb_buffer #(
    .payload_t (icb_pkg::cmd_t)
  ) u_cmd_buf (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (arbt_cmd_valid),
    .i_data  (arbt_cmd),
    .o_ready (arbt_cmd_ready),
    .o_valid (o_icb_cmd_valid),
    .o_data  (o_icb_cmd),
    .i_ready (i_icb_cmd_ready),
    .o_busy  (cmd_busy)
  );

  icb_rsp_route u_rsp_route (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_push_valid (push_valid),
    .i_push_mid   (push_mid),
    .o_push_ready (push_ready),
    .i_rsp_valid  (i_icb_rsp_valid),
    .i_rsp        (i_icb_rsp),
    .o_rsp_ready  (o_icb_rsp_ready),
    .o_rsp_valid  (mst_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_ready  (mst_rsp_ready),
    .o_busy       (rsp_busy)
  );

  assign o_active = cmd_busy | rsp_busy;

endmodule

// File: tests/icb_nto1_assert.sv
// Protocol assertions for the bus top level
// Stalled command stability, single response owner, outstanding limit
`timescale 1ns/1ps

module icb_nto1_assert (
  input logic          clk,
  input logic          i_rst,
  input logic          o_icb_cmd_valid,
  input icb_pkg::cmd_t o_icb_cmd,
  input logic          i_icb_cmd_ready,
  input logic          i_icb_rsp_valid,
  input logic          o_icb_rsp_ready,
  input logic          o0_rsp_valid,
  input logic          o1_rsp_valid
);

  logic [3:0] outs_cnt;
  logic       cmd_xfer;
  logic       rsp_xfer;

  assign cmd_xfer = o_icb_cmd_valid & i_icb_cmd_ready;
  assign rsp_xfer = i_icb_rsp_valid & o_icb_rsp_ready;

  // Downstream commands still waiting for a response
  always_ff @(posedge clk) begin
    if (i_rst) begin
      outs_cnt <= '0;
    end else begin
      outs_cnt <= outs_cnt + {3'd0, cmd_xfer} - {3'd0, rsp_xfer};
    end
  end

  cmd_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_icb_cmd_valid && !i_icb_cmd_ready |=> o_icb_cmd_valid && $stable(o_icb_cmd))
    else $error("downstream command changed while stalled");

  rsp_owner: assert property (@(posedge clk) disable iff (i_rst)
    !(o0_rsp_valid && o1_rsp_valid))
    else $error("both master response valids high");

  outs_limit: assert property (@(posedge clk) disable iff (i_rst)
    outs_cnt <= arbt_pkg::OUTS_NUM)
    else $error("too many downstream commands outstanding");

endmodule

bind icb_nto1_bus icb_nto1_assert u_assert (.*);

// File: tests/tb_icb_nto1.sv
// Testbench for the two-master bus
// Pattern reader, master and slave models, scoreboard, report
`timescale 1ns/1ps

module tb_icb_nto1;

  localparam string          PAT_FILE      = "tests/icb_nto1_patterns.txt";
  localparam int             CMD_TIMEOUT   = 2000;
  localparam int             DRAIN_TIMEOUT = 4000;
  localparam icb_pkg::addr_t ERR_BASE      = 16'hF000;

  logic           clk             = 1'b0;
  logic           i_rst           = 1'b1;
  logic [1:0]     m_cmd_valid     = 2'b00;
  icb_pkg::cmd_t  m_cmd [2]       = '{default: '0};
  logic [1:0]     m_rsp_ready     = 2'b00;
  logic           i_icb_cmd_ready = 1'b0;
  logic           i_icb_rsp_valid = 1'b0;
  icb_pkg::rsp_t  i_icb_rsp       = '0;
  wire  [1:0]     m_cmd_ready;
  wire  [1:0]     m_rsp_valid;
  icb_pkg::rsp_t  mst_rsp;
  logic           o_icb_cmd_valid;
  icb_pkg::cmd_t  o_icb_cmd;
  logic           o_icb_rsp_ready;
  logic           o_active;

  icb_pkg::cmd_t  pat [2][$];
  icb_pkg::cmd_t  exp_cmd [2][$];
  icb_pkg::rsp_t  exp_rsp [2][$];
  icb_pkg::cmd_t  slave_q [$];
  icb_pkg::data_t slave_mem [icb_pkg::addr_t];
  icb_pkg::data_t ref_mem [icb_pkg::addr_t];
  logic [31:0]    lfsr      = 32'hcdcc86a8;
  logic           stall_en  = 1'b0;
  logic           alt_en    = 1'b0;
  logic           rsp_taken = 1'b0;
  logic           timed_out = 1'b0;
  int             last_src  = -1;
  int             outs_cnt  = 0;
  int             in_flight = 0;
  int             rsp_held  = 0;
  int             rsp_delay = 0;
  int             err_cnt   = 0;
  int             n_cmd     = 0;
  int             n_rsp     = 0;

  always #5 clk = ~clk;

  icb_nto1_bus uut (
    .clk             (clk),
    .i_rst           (i_rst),
    .i0_cmd_valid    (m_cmd_valid[0]),
    .i1_cmd_valid    (m_cmd_valid[1]),
    .i0_cmd          (m_cmd[0]),
    .i1_cmd          (m_cmd[1]),
    .o0_cmd_ready    (m_cmd_ready[0]),
    .o1_cmd_ready    (m_cmd_ready[1]),
    .o0_rsp_valid    (m_rsp_valid[0]),
    .o1_rsp_valid    (m_rsp_valid[1]),
    .o_rsp           (mst_rsp),
    .i0_rsp_ready    (m_rsp_ready[0]),
    .i1_rsp_ready    (m_rsp_ready[1]),
    .o_icb_cmd_valid (o_icb_cmd_valid),
    .o_icb_cmd       (o_icb_cmd),
    .i_icb_cmd_ready (i_icb_cmd_ready),
    .i_icb_rsp_valid (i_icb_rsp_valid),
    .i_icb_rsp       (i_icb_rsp),
    .o_icb_rsp_ready (o_icb_rsp_ready),
    .o_active        (o_active)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic take_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic icb_pkg::data_t fill_word(icb_pkg::addr_t a);
    return {a ^ 16'h3c5a, ~a, a[7:0], a[15:8], a + 16'h1357};
  endfunction

  function automatic icb_pkg::data_t merge_word(icb_pkg::data_t old, icb_pkg::data_t wdata,
                                                icb_pkg::mask_t mask);
    icb_pkg::data_t res;
    res = old;
    for (int b = 0; b < icb_pkg::MW; b++) begin
      if (mask[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  // Shared memory model for the slave and the reference
  // Writes to the err range are dropped
  task automatic mem_access(input bit slave_side, input icb_pkg::cmd_t c,
                            output icb_pkg::rsp_t r);
    icb_pkg::data_t cur;
    if (slave_side) begin
      cur = slave_mem.exists(c.addr) ? slave_mem[c.addr] : fill_word(c.addr);
    end else begin
      cur = ref_mem.exists(c.addr) ? ref_mem[c.addr] : fill_word(c.addr);
    end
    r.err   = (c.addr >= ERR_BASE);
    r.rdata = c.read ? cur : '0;
    if (!c.read && !r.err) begin
      if (slave_side) slave_mem[c.addr] = merge_word(cur, c.wdata, c.wmask);
      else ref_mem[c.addr] = merge_word(cur, c.wdata, c.wmask);
    end
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic flag_timeout(input string msg);
    timed_out = 1'b1;
    $display("%0t: timeout, %s", $time, msg);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input icb_pkg::cmd_t exp, input icb_pkg::cmd_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input icb_pkg::rsp_t exp, input icb_pkg::rsp_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic load_patterns();
    int             fd;
    int             n;
    string          line;
    logic [3:0]     m_f;
    logic [3:0]     rd_f;
    icb_pkg::addr_t a_f;
    icb_pkg::data_t d_f;
    icb_pkg::mask_t k_f;
    icb_pkg::cmd_t  c;
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      note_failure("cannot open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h", m_f, rd_f, a_f, d_f, k_f);
      if (n == 5) begin
        c.read  = rd_f[0];
        c.addr  = a_f;
        c.wdata = d_f;
        c.wmask = k_f;
        pat[m_f[0]].push_back(c);
      end
    end
    $fclose(fd);
  endtask

  // Master model holds valid until the arbiter takes the command
  task automatic issue_cmds(input int m, input int first, input int num);
    icb_pkg::rsp_t r;
    int            wait_cnt;
    @(posedge clk);
    #1;
    for (int i = first; i < first + num; i++) begin
      m_cmd[m]       = pat[m][i];
      m_cmd_valid[m] = 1'b1;
      wait_cnt       = 0;
      @(negedge clk);
      while (!m_cmd_ready[m] && wait_cnt < CMD_TIMEOUT && !timed_out) begin
        wait_cnt++;
        @(negedge clk);
      end
      if (!m_cmd_ready[m]) begin
        flag_timeout($sformatf("master %0d command was never accepted", m));
        m_cmd_valid[m] = 1'b0;
        return;
      end
      mem_access(1'b0, pat[m][i], r);
      exp_cmd[m].push_back(pat[m][i]);
      exp_rsp[m].push_back(r);
      @(posedge clk);
      #1;
      m_cmd_valid[m] = 1'b0;
    end
  endtask

  function automatic bit bus_idle();
    return !i_icb_rsp_valid && slave_q.size() == 0 &&
           exp_cmd[0].size() == 0 && exp_cmd[1].size() == 0 &&
           exp_rsp[0].size() == 0 && exp_rsp[1].size() == 0;
  endfunction

  task automatic drain_bus();
    int n;
    n = 0;
    @(negedge clk);
    while (!bus_idle() && n < DRAIN_TIMEOUT && !timed_out) begin
      n++;
      @(negedge clk);
    end
    if (!bus_idle()) flag_timeout("traffic did not drain from the bus");
  endtask

  task automatic check_quiet();
    check_bit("o_icb_cmd_valid", 1'b0, o_icb_cmd_valid);
    check_bit("o0_rsp_valid", 1'b0, m_rsp_valid[0]);
    check_bit("o1_rsp_valid", 1'b0, m_rsp_valid[1]);
    check_bit("o_active", 1'b0, o_active);
  endtask

  task automatic report_test(input string name, input int errs);
    $display("%-28s %s", name, (err_cnt == errs && !timed_out) ? "ok" : "errors");
  endtask

  // Scoreboard sampled mid-cycle on the falling edge
  always @(negedge clk) begin : sample_bus
    int src;
    if (!i_rst) begin
      check_bit("o_active", in_flight != 0, o_active);
      check_bit("o_icb_rsp_ready", rsp_held < 2, o_icb_rsp_ready);
    end
    rsp_taken = i_icb_rsp_valid & o_icb_rsp_ready;
    for (int m = 0; m < 2; m++) begin
      if (m_cmd_valid[m] && m_cmd_ready[m]) in_flight++;
    end
    if (o_icb_cmd_valid && i_icb_cmd_ready) begin
      src = int'(o_icb_cmd.addr[15]);
      n_cmd++;
      outs_cnt++;
      if (alt_en && src == last_src) note_failure($sformatf("master %0d granted twice", src));
      last_src = src;
      if (exp_cmd[src].size() == 0) begin
        note_failure($sformatf("command from master %0d that was never issued", src));
      end else begin
        check_cmd("o_icb_cmd", exp_cmd[src].pop_front(), o_icb_cmd);
      end
      slave_q.push_back(o_icb_cmd);
    end
    if (rsp_taken) begin
      outs_cnt--;
      rsp_held++;
    end
    if (outs_cnt > arbt_pkg::OUTS_NUM) note_failure("too many commands outstanding");
    for (int m = 0; m < 2; m++) begin
      if (m_rsp_valid[m] && m_rsp_ready[m]) begin
        n_rsp++;
        in_flight--;
        rsp_held--;
        if (exp_rsp[m].size() == 0) begin
          note_failure($sformatf("master %0d got a response it did not ask for", m));
        end else begin
          check_rsp($sformatf("o_rsp master %0d", m), exp_rsp[m].pop_front(), mst_rsp);
        end
      end
    end
  end

  // Slave model answers in order after a random delay
  // Ready stalls come from the LFSR
  always @(posedge clk) begin : drive_slave
    #1;
    if (stall_en) begin
      i_icb_cmd_ready = take_bit();
      m_rsp_ready[0]  = take_bit();
      m_rsp_ready[1]  = take_bit();
    end else begin
      i_icb_cmd_ready = 1'b1;
      m_rsp_ready     = 2'b11;
    end
    if (rsp_taken) i_icb_rsp_valid = 1'b0;
    if (!i_icb_rsp_valid && slave_q.size() != 0) begin
      if (rsp_delay == 0) begin
        mem_access(1'b1, slave_q.pop_front(), i_icb_rsp);
        i_icb_rsp_valid = 1'b1;
        rsp_delay = take_bit();
        rsp_delay = rsp_delay * 2 + take_bit();
      end else begin
        rsp_delay--;
      end
    end
  end

  initial begin : main
    int errs;
    load_patterns();
    errs = err_cnt;
    for (int c = 0; c < 15; c++) begin
      @(negedge clk);
      check_quiet();
    end
    @(posedge clk);
    #1;
    i_rst = 1'b0;
    @(negedge clk);
    check_quiet();
    report_test("test 1 reset state", errs);

    errs = err_cnt;
    issue_cmds(0, 0, 2);
    drain_bus();
    report_test("test 2 masked write, read", errs);

    if (!timed_out) begin
      errs     = err_cnt;
      alt_en   = 1'b1;
      last_src = -1;
      fork
        issue_cmds(0, 2, pat[0].size() - 2);
        issue_cmds(1, 0, pat[1].size());
      join
      drain_bus();
      alt_en = 1'b0;
      report_test("test 3 alternating grants", errs);
    end

    if (!timed_out) begin
      errs     = err_cnt;
      stall_en = 1'b1;
      fork
        issue_cmds(0, 0, pat[0].size());
        issue_cmds(1, 0, pat[1].size());
      join
      drain_bus();
      stall_en = 1'b0;
      report_test("test 4 random stalls", errs);
    end

    errs = err_cnt;
    @(negedge clk);
    check_bit("o_active", 1'b0, o_active);
    if (outs_cnt != 0) note_failure("responses missing after the bus went idle");
    if (n_cmd != 2 * (pat[0].size() + pat[1].size()) || n_rsp != n_cmd) begin
      note_failure("command or response count does not match the patterns");
    end
    report_test("test 5 idle after traffic", errs);

    $display("tests done: %0d errors, %0d commands, %0d responses", err_cnt, n_cmd, n_rsp);
    if (err_cnt == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: icb_nto1.f
common/icb_pkg.sv
common/arbt_pkg.sv
verilog/icb_buffer.sv
arbt/icb_arbiter.sv
arbt/icb_rsp_route.sv
verilog/icb_nto1_bus.sv
tests/icb_nto1_assert.sv
tests/tb_icb_nto1.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icb_nto1
FILELIST  ?= icb_nto1.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Simulation failed" $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/icb_nto1_patterns.txt
// master read addr wdata mask, all hex
// master 0 stays below 16'h8000, master 1 at 16'h8000 and above
0 0 0040 1122334455667788 5a
0 1 0040 0000000000000000 00
0 0 0100 0123456789abcdef ff
0 0 0108 fedcba9876543210 0f
0 1 0100 0000000000000000 00
0 1 0108 0000000000000000 00
0 1 0200 0000000000000000 00
0 0 0200 a5a5a5a5a5a5a5a5 c3
0 1 0200 0000000000000000 00
0 0 0040 deadbeefcafef00d 81
0 1 0040 0000000000000000 00
0 1 7ff8 0000000000000000 00
0 0 7ff8 0f0f0f0f0f0f0f0f 3c
0 1 7ff8 0000000000000000 00
1 0 8000 8877665544332211 ff
1 1 8000 0000000000000000 00
1 0 8010 0000111122223333 f0
1 1 8010 0000000000000000 00
1 1 f000 0000000000000000 00
1 0 f008 1234123412341234 ff
1 1 f008 0000000000000000 00
1 0 9abc 5555aaaa5555aaaa 33
1 1 9abc 0000000000000000 00
1 1 fff8 0000000000000000 00
1 0 8000 0102030405060708 18
1 1 8000 0000000000000000 00
